//--- verilog/csr_pkg.sv
// Data width, CSR addresses, write masks, reset values, CSR operation codes and request struct
package csr_pkg;

  localparam int xlen = 64;

  // Machine-mode CSR addresses
  localparam logic [11:0] addr_mstatus   = 12'h300;
  localparam logic [11:0] addr_misa      = 12'h301;
  localparam logic [11:0] addr_mie       = 12'h304;
  localparam logic [11:0] addr_mtvec     = 12'h305;
  localparam logic [11:0] addr_mscratch  = 12'h340;
  localparam logic [11:0] addr_mepc      = 12'h341;
  localparam logic [11:0] addr_mcause    = 12'h342;
  localparam logic [11:0] addr_mtval     = 12'h343;
  localparam logic [11:0] addr_mip       = 12'h344;
  localparam logic [11:0] addr_mcycle    = 12'hb00;
  localparam logic [11:0] addr_mvendorid = 12'hf11;
  localparam logic [11:0] addr_marchid   = 12'hf12;
  localparam logic [11:0] addr_mimpid    = 12'hf13;
  localparam logic [11:0] addr_mhartid   = 12'hf14;

  localparam logic [xlen-1:0] mstatus_mask  = 64'h8000_0000_0001_f888; // SD, XS, FS, MPP, MPIE, MIE
  localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_0000_1880; // MPP = 3, MPIE set
  localparam logic [xlen-1:0] mie_reset     = 64'h0000_0000_0000_0888;
  localparam logic [xlen-1:0] mip_reset     = 64'h0000_0000_0000_0080;

  // MXL = 2 (RV64) and the I base only
  localparam logic [xlen-1:0] misa_value = 64'h8000_0000_0000_0100;

  // Encoded as funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    op_rw  = 3'b001,
    op_rs  = 3'b010,
    op_rc  = 3'b011,
    op_rwi = 3'b101,
    op_rsi = 3'b110,
    op_rci = 3'b111
  } csr_op_e;

  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    logic [11:0]     addr;
    logic [xlen-1:0] src;   // rs1 or zero-extended uimm
  } csr_req_t;

endpackage

//--- verilog/trap_pkg.sv
// Trap cause codes and the request, write and read bundles between trap unit and CSR file
package trap_pkg;

  // Interrupt causes carry the top bit
  localparam logic [csr_pkg::xlen-1:0] cause_illegal_instr = 64'd2;
  localparam logic [csr_pkg::xlen-1:0] cause_ecall_m       = 64'd11;
  localparam logic [csr_pkg::xlen-1:0] cause_m_timer_irq   = 64'h8000_0000_0000_0007;

  typedef struct packed {
    logic                     enter;  // One-cycle strobe
    logic                     mret;   // One-cycle strobe
    logic [csr_pkg::xlen-1:0] cause;
    logic [csr_pkg::xlen-1:0] pc;
    logic [csr_pkg::xlen-1:0] tval;
  } trap_req_t;

  // Trap unit to CSR file
  typedef struct packed {
    logic                     wr;
    logic                     enter;  // Low on mret, only mstatus is written then
    logic [csr_pkg::xlen-1:0] mstatus;
    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] mcause;
    logic [csr_pkg::xlen-1:0] mtval;
  } trap_wr_t;

  // CSR file to trap unit
  typedef struct packed {
    logic [csr_pkg::xlen-1:0] mstatus;
    logic [csr_pkg::xlen-1:0] mtvec;
    logic [csr_pkg::xlen-1:0] mepc;
    logic [csr_pkg::xlen-1:0] mie;
    logic [csr_pkg::xlen-1:0] mip;
  } trap_rd_t;

endpackage

//--- verilog/csr_op_unit.sv
// Read-modify-write data for csrrw/csrrs/csrrc and illegal CSR access detection
`timescale 1ns/1ps

module csr_op_unit (
  input  csr_pkg::csr_req_t        req,
  input  logic                     commit,
  input  logic [csr_pkg::xlen-1:0] old_value,
  input  logic                     addr_valid,
  output logic                     wr_en,
  output logic [11:0]              wr_addr,
  output logic [csr_pkg::xlen-1:0] wr_data,
  output logic                     illegal
);

  import csr_pkg::*;

  logic set_or_clear;
  logic writes;
  logic read_only;

  always_comb begin
    case (req.op)
      op_rs, op_rsi: wr_data = old_value | req.src;
      op_rc, op_rci: wr_data = old_value & ~req.src;
      default:       wr_data = req.src;   // Plain replace
    endcase
  end

  assign set_or_clear = req.op inside {op_rs, op_rsi, op_rc, op_rci};

  // Set or clear with a zero source is a pure read
  assign writes = !(set_or_clear && (req.src == '0));

  // ID registers at 0xF1x and misa do not take writes
  assign read_only = (req.addr[11:4] == 8'hf1) || (req.addr == addr_misa);

  assign illegal = req.valid && (!addr_valid || (writes && read_only));

  assign wr_en   = commit && req.valid && writes && !illegal;
  assign wr_addr = req.addr;

endmodule

//--- verilog/csr_file.sv
// Machine-mode CSR storage with masked writes, trap writes, read decode and cycle counter
`timescale 1ns/1ps

module csr_file #(
  parameter logic [csr_pkg::xlen-1:0] HART_ID     = '0,
  parameter logic [csr_pkg::xlen-1:0] MTVEC_RESET = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [11:0]              rd_addr,
  output logic [csr_pkg::xlen-1:0] rd_data,
  output logic                     addr_valid,
  input  logic                     wr_en,
  input  logic [11:0]              wr_addr,
  input  logic [csr_pkg::xlen-1:0] wr_data,
  input  trap_pkg::trap_wr_t       trap_wr,
  input  logic [csr_pkg::xlen-1:0] mip_next,
  output trap_pkg::trap_rd_t       trap_rd
);

  import csr_pkg::*;

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mie_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic [xlen-1:0] mip_q;
  logic [xlen-1:0] mcycle_q;

  logic wr_mstatus, wr_mie, wr_mtvec, wr_mscratch;
  logic wr_mepc, wr_mcause, wr_mtval, wr_mcycle;
  logic trap_entry;

  logic [xlen-1:0] trap_mstatus;
  logic [xlen-1:0] mstatus_rd;
  logic [xlen-1:0] mepc_rd;
  logic [xlen-1:0] mcause_rd;
  logic [xlen-1:0] mtval_rd;
  logic [xlen-1:0] rd_value;

  // Keep the writable bits and derive SD from FS and XS
  function automatic logic [xlen-1:0] mstatus_fix(input logic [xlen-1:0] value);
    logic [xlen-1:0] fixed;
    fixed = value & mstatus_mask;
    fixed[xlen-1] = (fixed[14:13] == 2'b11) || (fixed[16:15] == 2'b11);
    return fixed;
  endfunction

  assign wr_mstatus  = wr_en && (wr_addr == addr_mstatus);
  assign wr_mie      = wr_en && (wr_addr == addr_mie);
  assign wr_mtvec    = wr_en && (wr_addr == addr_mtvec);
  assign wr_mscratch = wr_en && (wr_addr == addr_mscratch);
  assign wr_mepc     = wr_en && (wr_addr == addr_mepc);
  assign wr_mcause   = wr_en && (wr_addr == addr_mcause);
  assign wr_mtval    = wr_en && (wr_addr == addr_mtval);
  assign wr_mcycle   = wr_en && (wr_addr == addr_mcycle);

  assign trap_entry   = trap_wr.wr && trap_wr.enter;
  assign trap_mstatus = mstatus_fix(trap_wr.mstatus);

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= mstatus_reset;
      mie_q      <= mie_reset;
      mtvec_q    <= MTVEC_RESET;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= mip_reset;
      mcycle_q   <= '0;
    end else begin
      // Trap side wins over an instruction write
      if (trap_wr.wr) begin
        mstatus_q <= trap_mstatus;
      end else if (wr_mstatus) begin
        mstatus_q <= mstatus_fix(wr_data);
      end

      if (trap_entry) begin
        mepc_q   <= trap_wr.mepc;
        mcause_q <= trap_wr.mcause;
        mtval_q  <= trap_wr.mtval;
      end else begin
        if (wr_mepc) mepc_q <= wr_data;
        if (wr_mcause) mcause_q <= wr_data;
        if (wr_mtval) mtval_q <= wr_data;
      end

      if (wr_mie) mie_q <= wr_data;
      if (wr_mtvec) mtvec_q <= wr_data;
      if (wr_mscratch) mscratch_q <= wr_data;

      mip_q <= mip_next;  // Interrupt lines are sampled every cycle

      if (wr_mcycle) begin
        mcycle_q <= wr_data;
      end else begin
        mcycle_q <= mcycle_q + 1'b1;
      end
    end
  end

  // Trap results show up on the read port in the strobe cycle
  assign mstatus_rd = trap_wr.wr ? trap_mstatus : mstatus_q;
  assign mepc_rd    = trap_entry ? trap_wr.mepc : mepc_q;
  assign mcause_rd  = trap_entry ? trap_wr.mcause : mcause_q;
  assign mtval_rd   = trap_entry ? trap_wr.mtval : mtval_q;

  always_comb begin
    addr_valid = 1'b1;
    rd_value   = '0;
    case (rd_addr)
      addr_mstatus:  rd_value = mstatus_rd;
      addr_misa:     rd_value = misa_value;
      addr_mie:      rd_value = mie_q;
      addr_mtvec:    rd_value = mtvec_q;
      addr_mscratch: rd_value = mscratch_q;
      addr_mepc:     rd_value = mepc_rd;
      addr_mcause:   rd_value = mcause_rd;
      addr_mtval:    rd_value = mtval_rd;
      addr_mip:      rd_value = mip_q;
      addr_mcycle:   rd_value = mcycle_q + 1'b1;  // Value after this cycle
      addr_mvendorid, addr_marchid, addr_mimpid: begin
        rd_value = '0;
      end
      addr_mhartid:  rd_value = HART_ID;
      default:       addr_valid = 1'b0;
    endcase
  end

  assign rd_data = rst ? '0 : rd_value;

  // Stored state for the trap unit
  assign trap_rd.mstatus = mstatus_q;
  assign trap_rd.mtvec   = mtvec_q;
  assign trap_rd.mepc    = mepc_q;
  assign trap_rd.mie     = mie_q;
  assign trap_rd.mip     = mip_q;

endmodule

//--- verilog/trap_unit.sv
// Trap entry and mret state updates, trap target pc and the machine timer interrupt decision
`timescale 1ns/1ps

module trap_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  trap_pkg::trap_req_t      req,
  input  logic                     timer_irq,
  input  trap_pkg::trap_rd_t       csr,
  output trap_pkg::trap_wr_t       trap_wr,
  output logic [csr_pkg::xlen-1:0] mip_next,
  output logic [csr_pkg::xlen-1:0] trap_pc,
  output logic                     trap_pc_valid,
  output logic                     irq_pending
);

  import csr_pkg::*;

  localparam int mie_bit  = 3;    // mstatus.MIE
  localparam int mpie_bit = 7;    // mstatus.MPIE
  localparam int mpp_lo   = 11;   // mstatus.MPP
  localparam int mtip_bit = 7;    // mip.MTIP and mie.MTIE

  logic [xlen-1:0] mstatus_entry;
  logic [xlen-1:0] mstatus_mret;

  always_comb begin
    mstatus_entry = csr.mstatus;
    mstatus_entry[mpie_bit] = csr.mstatus[mie_bit];
    mstatus_entry[mie_bit] = 1'b0;
    mstatus_entry[mpp_lo+1:mpp_lo] = 2'b11;   // Only machine mode exists
  end

  always_comb begin
    mstatus_mret = csr.mstatus;
    mstatus_mret[mie_bit] = csr.mstatus[mpie_bit];
    mstatus_mret[mpie_bit] = 1'b1;
    mstatus_mret[mpp_lo+1:mpp_lo] = 2'b11;
  end

  assign trap_wr.wr      = req.enter || req.mret;
  assign trap_wr.enter   = req.enter;
  assign trap_wr.mstatus = req.enter ? mstatus_entry : mstatus_mret;
  assign trap_wr.mepc    = {req.pc[xlen-1:1], 1'b0};
  assign trap_wr.mcause  = req.cause;
  assign trap_wr.mtval   = req.tval;

  // Direct mode only, the mode field is dropped
  always_ff @(posedge clk) begin
    if (req.enter) begin
      trap_pc <= {csr.mtvec[xlen-1:2], 2'b00};
    end else if (req.mret) begin
      trap_pc <= csr.mepc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      trap_pc_valid <= 1'b0;
    end else begin
      trap_pc_valid <= req.enter || req.mret;
    end
  end

  always_comb begin
    mip_next = csr.mip;
    mip_next[mtip_bit] = timer_irq;   // Lands in mip at the next edge
  end

  assign irq_pending = csr.mstatus[mie_bit] && csr.mie[mtip_bit] && csr.mip[mtip_bit];

endmodule

//--- verilog/csr_top.sv
// CSR subsystem top connecting the operation unit, the register file and the trap unit
`timescale 1ns/1ps

module csr_top #(
  parameter logic [csr_pkg::xlen-1:0] HART_ID     = '0,
  parameter logic [csr_pkg::xlen-1:0] MTVEC_RESET = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_req_t        csr_req,
  input  logic                     csr_commit,
  input  trap_pkg::trap_req_t      trap_req,
  input  logic                     timer_irq,
  output logic [csr_pkg::xlen-1:0] csr_rdata,
  output logic                     csr_illegal,
  output logic [csr_pkg::xlen-1:0] trap_pc,
  output logic                     trap_pc_valid,
  output logic                     irq_pending
);

  import csr_pkg::*;
  import trap_pkg::*;

  logic            addr_valid;
  logic            wr_en;
  logic [11:0]     wr_addr;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] mip_next;
  trap_wr_t        trap_wr;
  trap_rd_t        trap_rd;

  csr_op_unit u_op (
    .req        (csr_req),
    .commit     (csr_commit),
    .old_value  (csr_rdata),
    .addr_valid (addr_valid),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .illegal    (csr_illegal)
  );

  csr_file #(
    .HART_ID     (HART_ID),
    .MTVEC_RESET (MTVEC_RESET)
  ) u_file (
    .clk        (clk),
    .rst        (rst),
    .rd_addr    (csr_req.addr),
    .rd_data    (csr_rdata),
    .addr_valid (addr_valid),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .trap_wr    (trap_wr),
    .mip_next   (mip_next),
    .trap_rd    (trap_rd)
  );

  trap_unit u_trap (
    .clk           (clk),
    .rst           (rst),
    .req           (trap_req),
    .timer_irq     (timer_irq),
    .csr           (trap_rd),
    .trap_wr       (trap_wr),
    .mip_next      (mip_next),
    .trap_pc       (trap_pc),
    .trap_pc_valid (trap_pc_valid),
    .irq_pending   (irq_pending)
  );

endmodule

//--- testbench/csr_model.svh
// Shadow CSR registers, shadow reset, read and update, and expected-value functions
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

  logic [xlen-1:0] sh_mstatus;
  logic [xlen-1:0] sh_mie;
  logic [xlen-1:0] sh_mtvec;
  logic [xlen-1:0] sh_mscratch;
  logic [xlen-1:0] sh_mepc;
  logic [xlen-1:0] sh_mcause;
  logic [xlen-1:0] sh_mtval;

  function automatic logic [xlen-1:0] expected_rw(input csr_op_e op,
                                                  input logic [xlen-1:0] old_value,
                                                  input logic [xlen-1:0] src);
    if (op == op_rs || op == op_rsi) return old_value | src;
    if (op == op_rc || op == op_rci) return old_value & ~src;
    return src;  // csrrw and csrrwi replace
  endfunction

  // Only SD, XS, FS, MPP, MPIE and MIE survive
  function automatic logic [xlen-1:0] mstatus_after_write(input logic [xlen-1:0] value);
    logic [xlen-1:0] result;
    result = value & 64'h8000_0000_0001_f888;
    result[63] = (result[14:13] == 2'b11) || (result[16:15] == 2'b11);  // SD for dirty FS or XS
    return result;
  endfunction

  function automatic logic [xlen-1:0] mstatus_after_entry(input logic [xlen-1:0] value);
    logic [xlen-1:0] result;
    result = value;
    result[7] = value[3];     // MPIE takes MIE
    result[3] = 1'b0;
    result[12:11] = 2'b11;    // Previous mode is M
    return result;
  endfunction

  function automatic logic [xlen-1:0] mstatus_after_mret(input logic [xlen-1:0] value);
    logic [xlen-1:0] result;
    result = value;
    result[3] = value[7];     // MIE restored from MPIE
    result[7] = 1'b1;
    result[12:11] = 2'b11;
    return result;
  endfunction

  task automatic reset_model();
    sh_mstatus  = mstatus_reset;
    sh_mie      = mie_reset;
    sh_mtvec    = MTVEC_RESET;
    sh_mscratch = '0;
    sh_mepc     = '0;
    sh_mcause   = '0;
    sh_mtval    = '0;
  endtask

  function automatic logic [xlen-1:0] shadow_value(input logic [11:0] addr);
    case (addr)
      addr_mstatus:  return sh_mstatus;
      addr_mie:      return sh_mie;
      addr_mtvec:    return sh_mtvec;
      addr_mscratch: return sh_mscratch;
      default:       return '0;
    endcase
  endfunction

  task automatic shadow_write(input logic [11:0] addr, input logic [xlen-1:0] value);
    case (addr)
      addr_mstatus:  sh_mstatus = mstatus_after_write(value);
      addr_mie:      sh_mie = value;
      addr_mtvec:    sh_mtvec = value;
      addr_mscratch: sh_mscratch = value;
      default:       ;
    endcase
  endtask

`endif

//--- testbench/csr_tb.sv
// CSR subsystem testbench with clock, reset, stimulus, compare process and test sequence
`timescale 1ns/1ps

module csr_tb;

  import csr_pkg::*;
  import trap_pkg::*;

  localparam logic [xlen-1:0] HART_ID     = 64'h0000_0000_0000_0005;
  localparam logic [xlen-1:0] MTVEC_RESET = 64'h0000_0000_8000_0101;
  localparam int wait_limit = 16;

  logic            clk, rst, csr_commit, timer_irq;
  csr_req_t        csr_req;
  trap_req_t       trap_req;
  logic [xlen-1:0] csr_rdata, trap_pc;
  logic            csr_illegal, trap_pc_valid, irq_pending;

  logic            expect_on;  // Arms the compare process for one cycle
  logic [xlen-1:0] expect_rdata;
  logic            expect_illegal;

  integer seed;
  int     checks;
  int     errors;
  int     errors_at_start;

  `include "csr_model.svh"

  csr_top #(.HART_ID(HART_ID), .MTVEC_RESET(MTVEC_RESET)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("timeout after %0d cycles waiting for %s", wait_limit, reason);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished with %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  function automatic logic [xlen-1:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // One request cycle with commit, then one idle cycle
  task automatic run_csr(input csr_op_e op, input logic [11:0] addr, input logic [xlen-1:0] src,
                         input logic [xlen-1:0] old_value, input logic illegal);
    csr_req_t req;
    req.valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.src   = src;
    @(posedge clk);
    csr_req        <= req;
    csr_commit     <= 1'b1;
    expect_on      <= 1'b1;
    expect_rdata   <= old_value;
    expect_illegal <= illegal;
    @(posedge clk);
    csr_req.valid <= 1'b0;
    csr_commit    <= 1'b0;
    expect_on     <= 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr, input logic [xlen-1:0] expected);
    run_csr(op_rs, addr, '0, expected, 1'b0);  // Zero source does not write
  endtask

  task automatic access_csr(input csr_op_e op, input logic [11:0] addr,
                            input logic [xlen-1:0] src);
    logic [xlen-1:0] old_value;
    old_value = shadow_value(addr);
    run_csr(op, addr, src, old_value, 1'b0);
    shadow_write(addr, expected_rw(op, old_value, src));
  endtask

  task automatic random_access(input logic [11:0] addr);
    csr_op_e         ops [6] = '{op_rw, op_rs, op_rc, op_rwi, op_rsi, op_rci};
    csr_op_e         op;
    logic [xlen-1:0] src;
    op  = ops[$unsigned($random(seed)) % 6];
    src = random_word();
    if (op inside {op_rwi, op_rsi, op_rci}) src = {59'd0, src[4:0]};  // uimm
    access_csr(op, addr, src);
  endtask

  // Strobe cycle also reads one CSR, which must already show the trap result
  task automatic pulse_trap(input logic enter, input logic mret, input logic [xlen-1:0] cause,
                            input logic [xlen-1:0] pc, input logic [xlen-1:0] tval,
                            input logic [11:0] rd_addr, input logic [xlen-1:0] rd_expected);
    trap_req_t req;
    csr_req_t  probe;
    req.enter   = enter;
    req.mret    = mret;
    req.cause   = cause;
    req.pc      = pc;
    req.tval    = tval;
    probe.valid = 1'b1;
    probe.op    = op_rs;
    probe.addr  = rd_addr;
    probe.src   = '0;
    @(posedge clk);
    trap_req <= req;
    csr_req  <= probe;
    @(negedge clk);
    check_value("csr_rdata in trap cycle", csr_rdata, rd_expected);
    @(posedge clk);
    trap_req      <= '0;
    csr_req.valid <= 1'b0;
  endtask

  // Falling edges until trap_pc_valid (irq low) or irq_pending (irq high) reaches level
  task automatic wait_level(input logic irq, input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) abort_run(irq ? "irq_pending" : "trap_pc_valid");
    end while ((irq ? irq_pending : trap_pc_valid) !== level);
  endtask

  always @(negedge clk) begin
    if (expect_on) begin
      check_value("csr_rdata", csr_rdata, expect_rdata);
      check_value("csr_illegal", 64'(csr_illegal), 64'(expect_illegal));
    end
  end

  initial begin
    int              cycles;
    int              gap;
    logic [xlen-1:0] count;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] causes [3];
    csr_req_t        probe;

    seed = 32'hbbe7;
    checks = 0;
    errors = 0;
    errors_at_start = 0;
    causes = '{cause_ecall_m, cause_illegal_instr, cause_m_timer_irq};
    rst = 1'b1;
    csr_commit = 1'b0;
    timer_irq = 1'b0;
    trap_req = '0;
    csr_req = '0;
    csr_req.valid = 1'b1;   // mstatus read held through reset
    csr_req.op = op_rs;
    csr_req.addr = addr_mstatus;
    expect_on = 1'b0;
    expect_rdata = '0;
    expect_illegal = 1'b0;
    reset_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("csr_rdata in reset", csr_rdata, '0);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("csr_illegal after reset", 64'(csr_illegal), '0);
    check_value("trap_pc_valid after reset", 64'(trap_pc_valid), '0);
    check_value("irq_pending after reset", 64'(irq_pending), '0);

    read_csr(addr_mstatus, mstatus_reset);
    read_csr(addr_mie, mie_reset);
    read_csr(addr_mip, '0);   // MTIP mirrors the idle timer line
    read_csr(addr_mtvec, MTVEC_RESET);
    read_csr(addr_misa, misa_value);
    read_csr(addr_mhartid, HART_ID);
    read_csr(addr_mvendorid, '0);
    finish_test("reset_values");

    repeat (60) begin
      case ($unsigned($random(seed)) % 3)
        0:       random_access(addr_mscratch);
        1:       random_access(addr_mtvec);
        default: random_access(addr_mie);
      endcase
    end
    read_csr(addr_mscratch, sh_mscratch);
    read_csr(addr_mtvec, sh_mtvec);
    read_csr(addr_mie, sh_mie);
    finish_test("csr_instructions");

    repeat (30) random_access(addr_mstatus);
    read_csr(addr_mstatus, sh_mstatus);
    run_csr(op_rw, addr_misa, random_word(), misa_value, 1'b1);
    run_csr(op_rs, addr_mhartid, 64'h1, HART_ID, 1'b1);
    run_csr(op_rwi, addr_marchid, 64'h1f, '0, 1'b1);
    run_csr(op_rw, 12'h7c0, random_word(), '0, 1'b1);   // Not implemented
    run_csr(op_rs, 12'h3a0, '0, '0, 1'b1);              // Even a plain read
    read_csr(addr_misa, misa_value);
    read_csr(addr_mhartid, HART_ID);
    read_csr(addr_mstatus, sh_mstatus);
    read_csr(addr_mscratch, sh_mscratch);
    finish_test("mstatus_masking");

    foreach (causes[i]) begin
      random_access(addr_mstatus);   // Random MIE and MPIE ahead of the trap
      access_csr(op_rw, addr_mtvec, random_word());
      pc = random_word();
      count = random_word();
      sh_mepc = {pc[xlen-1:1], 1'b0};
      pulse_trap(1'b1, 1'b0, causes[i], pc, count, addr_mepc, sh_mepc);
      wait_level(1'b0, 1'b1, cycles);
      check_value("trap_pc_valid latency", 64'(cycles), 64'd1);
      check_value("trap_pc after entry", trap_pc, {sh_mtvec[xlen-1:2], 2'b00});
      @(negedge clk);
      check_value("trap_pc_valid after pulse", 64'(trap_pc_valid), '0);
      sh_mcause = causes[i];
      sh_mtval = count;
      sh_mstatus = mstatus_after_entry(sh_mstatus);
      read_csr(addr_mepc, sh_mepc);
      read_csr(addr_mcause, sh_mcause);
      read_csr(addr_mtval, sh_mtval);
      read_csr(addr_mstatus, sh_mstatus);
      sh_mstatus = mstatus_after_mret(sh_mstatus);
      pulse_trap(1'b0, 1'b1, '0, '0, '0, addr_mstatus, sh_mstatus);
      wait_level(1'b0, 1'b1, cycles);
      check_value("trap_pc after mret", trap_pc, sh_mepc);
      read_csr(addr_mstatus, sh_mstatus);
    end
    finish_test("trap_entry_mret");

    access_csr(op_rs, addr_mie, 64'h80);      // MTIE
    access_csr(op_rsi, addr_mstatus, 64'h8);  // MIE
    @(posedge clk);
    timer_irq <= 1'b1;
    wait_level(1'b1, 1'b1, cycles);
    check_value("irq_pending latency", 64'(cycles), 64'd2);
    read_csr(addr_mip, 64'h80);
    access_csr(op_rc, addr_mie, 64'h80);
    wait_level(1'b1, 1'b0, cycles);
    access_csr(op_rs, addr_mie, 64'h80);
    wait_level(1'b1, 1'b1, cycles);
    access_csr(op_rci, addr_mstatus, 64'h8);
    wait_level(1'b1, 1'b0, cycles);
    @(posedge clk);
    timer_irq <= 1'b0;
    read_csr(addr_mip, '0);
    finish_test("timer_irq");

    repeat (3) begin
      probe.valid = 1'b1;
      probe.op = op_rs;
      probe.addr = addr_mcycle;
      probe.src = '0;
      @(posedge clk);
      csr_req <= probe;
      @(negedge clk);
      count = csr_rdata;
      gap = 1 + $unsigned($random(seed)) % 40;
      repeat (gap) @(negedge clk);
      check_value("mcycle distance", csr_rdata - count, 64'(gap));
      count = random_word();
      probe.op = op_rw;
      probe.src = count;
      @(posedge clk);
      csr_req <= probe;
      csr_commit <= 1'b1;
      @(posedge clk);
      csr_commit <= 1'b0;
      csr_req.op <= op_rs;
      csr_req.src <= '0;
      gap = 1 + $unsigned($random(seed)) % 20;
      repeat (gap) @(negedge clk);   // Counted from the commit cycle
      check_value("mcycle after write", csr_rdata, count + 64'(gap));
      @(posedge clk);
      csr_req.valid <= 1'b0;
    end
    finish_test("cycle_counter");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+testbench
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_op_unit.sv
verilog/csr_file.sv
verilog/trap_unit.sv
verilog/csr_top.sv
testbench/csr_tb.sv

//--- Makefile
# Verilator build and simulation of the CSR subsystem testbench

TOP = csr_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "Simulation reported failures, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation finished without failures"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
